/* compile.f */
common/execute_pkg.sv
execute/adder_unit.sv
execute/logic_unit.sv
execute/shift_unit.sv
execute/branch_unit.sv
execute/execute_stage.sv
verification/tb_clock.sv
verification/execute_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps -f compile.f \
    --top-module execute_tb -o execute_sim &&
./obj_dir/execute_sim | tee /dev/stderr | grep -qx "test passed" &&
echo "Simulation PASS" ||
{ echo "Simulation FAIL"; exit 1; }

/* verification/execute_tb.sv */
module execute_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import execute_pkg::*;

    localparam int NUM_REQ     = 400;           // Random requests sent
    localparam int CLK_NS      = 4;
    localparam int WATCHDOG_NS = (NUM_REQ + 3 + 8) * CLK_NS + 200;

    logic     clk;
    logic     reset_i;
    exe_req_t req;                              // Driven into the DUT
    exe_rsp_t rsp;                              // Observed from the DUT

    integer   seed   = 76625;
    int       errors = 0;
    int       checks = 0;
    exe_rsp_t expected_q[$];                    // One response in flight

    tb_clock u_clock (.clk_o(clk), .reset_o(reset_i));

    execute_stage uut (
        .clk,
        .reset_i,
        .req_i (req),
        .rsp_o (rsp)
    );

    ////////////////////
    // Compare tasks
    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_response(input exe_rsp_t exp);
        check_word("rsp_o.result0", rsp.result0, exp.result0);
        check_word("rsp_o.result1", rsp.result1, exp.result1);
        check_bit("rsp_o.jump", rsp.jump, exp.jump);
        check_bit("rsp_o.we", rsp.we, exp.we);
        check_tag("rsp_o.tag", rsp.tag, exp.tag);
    endtask

    task automatic check_idle();
        check_bit("rsp_o.we", rsp.we, 1'b0);    // Nothing retired yet
        check_bit("rsp_o.jump", rsp.jump, 1'b0);
    endtask

    ////////////////////
    // Reference model
    function automatic exe_rsp_t model_rsp(input exe_req_t r);
        exe_rsp_t e;
        int       shamt;
        word_t    fill;                         // Sign bits shifted in by SRA
        logic     eq;
        logic     lt_s;
        logic     lt_u;
        e     = '0;
        e.tag = r.tag;
        shamt = int'(r.op_b[4:0]);
        fill  = r.op_a[31] ? ~(32'hFFFF_FFFF >> shamt) : 32'h0;
        eq    = r.op_a == r.op_b;
        lt_u  = r.op_a < r.op_b;
        lt_s  = (r.op_a ^ 32'h8000_0000) < (r.op_b ^ 32'h8000_0000);  // Offset binary
        if (r.op == OP_NOTOKEN) begin
            e.we = 1'b0;                        // Bubble leaves all zeros
        end else if (r.xu == XU_BYPASS) begin
            e.result0 = r.op_b;
            e.we      = 1'b1;
        end else begin
            e.we = 1'b1;
            case (r.op)
                OP_ADD:  e.result0 = r.op_a + r.op_b;
                OP_SUB:  e.result0 = r.op_a - r.op_b;
                OP_SLT:  e.result0 = {31'b0, lt_s};
                OP_SLTU: e.result0 = {31'b0, lt_u};
                OP_AND:  e.result0 = r.op_a & r.op_b;
                OP_OR:   e.result0 = r.op_a | r.op_b;
                OP_XOR:  e.result0 = r.op_a ^ r.op_b;
                OP_SLL:  e.result0 = r.op_a << shamt;
                OP_SRL:  e.result0 = r.op_a >> shamt;
                OP_SRA:  e.result0 = (r.op_a >> shamt) | fill;
                OP_JAL, OP_JALR: begin
                    e.result0 = r.npc + 32'd4;  // Link
                    e.result1 = (r.op == OP_JAL) ? r.npc + r.op_c
                                                 : (r.op_a + r.op_c) & 32'hFFFF_FFFE;
                    e.jump    = 1'b1;
                end
                default: begin                  // Conditional branches
                    e.we      = 1'b0;
                    e.result1 = r.npc + r.op_c;
                    e.jump    = (r.op == OP_BEQ  && eq)    || (r.op == OP_BNE  && !eq) ||
                                (r.op == OP_BLT  && lt_s)  || (r.op == OP_BGE  && !lt_s) ||
                                (r.op == OP_BLTU && lt_u)  || (r.op == OP_BGEU && !lt_u);
                end
            endcase
        end
        return e;
    endfunction

    ////////////////////
    // Random requests
    task automatic make_request(input int idx, output exe_req_t r);
        int unsigned pick;
        r          = '0;
        r.npc      = $random(seed);
        r.npc[1:0] = 2'b00;                     // Word aligned
        r.op_a     = $random(seed);
        r.op_b     = $random(seed);
        r.op_c     = $random(seed);
        pick       = $unsigned($random(seed));
        if (pick % 4 == 0) r.op_b = r.op_a;     // Equal operands for taken branches
        pick = $unsigned($random(seed));
        r.xu = xu_e'(pick % 5);
        pick = $unsigned($random(seed));
        case (r.xu)
            XU_ADDER:  r.op = op_e'(int'(OP_ADD) + int'(pick % 4));
            XU_LOGIC:  r.op = op_e'(int'(OP_AND) + int'(pick % 3));
            XU_SHIFT:  r.op = op_e'(int'(OP_SLL) + int'(pick % 3));
            XU_BRANCH: r.op = op_e'(int'(OP_BEQ) + int'(pick % 8));
            default:   r.op = op_e'(1 + int'(pick % 18));  // Any real op
        endcase
        pick = $unsigned($random(seed));
        if (pick % 8 == 0) r.op = OP_NOTOKEN;   // About one bubble in eight
        r.tag = tag_t'(idx);
    endtask

    ////////////////////
    // Stimulus and checking
    initial begin : stimulus
        exe_req_t next_req;
        req <= '0;
        @(negedge clk);
        while (reset_i) begin
            check_idle();
            @(negedge clk);
        end
        check_idle();                           // Reset state still shown
        for (int i = 0; i < NUM_REQ; i++) begin
            make_request(i, next_req);
            @(posedge clk);
            req <= next_req;
            @(negedge clk);                     // Previous request now on rsp_o
            if (expected_q.size() != 0) begin
                check_response(expected_q.pop_front());
            end else begin
                check_idle();
            end
            expected_q.push_back(model_rsp(next_req));
        end
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        check_response(expected_q.pop_front()); // Last request retires
        $display("execute_tb: %0d requests, %0d checks, %0d errors", NUM_REQ, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Simulation timed out after %0d ns before all requests retired",
                 WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

endmodule

/* verification/tb_clock.sv */
module tb_clock (
    output logic clk_o,                         // Free running clock
    output logic reset_o                        // Synchronous reset, active high
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 2;            // 4 ns period
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        reset_o <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;                        // Released on a rising edge
    end

endmodule

/* execute/execute_stage.sv */
module execute_stage (
    input  logic                  clk,
    input  logic                  reset_i,
    input  execute_pkg::exe_req_t req_i,        // One request per cycle
    output execute_pkg::exe_rsp_t rsp_o         // Result one cycle later
);
    import execute_pkg::*;

    unit_req_t req_fields;                      // Request minus routing fields
    unit_req_t adder_req;
    unit_req_t logic_req;
    unit_req_t shift_req;
    unit_req_t branch_req;
    logic      bubble;                          // Incoming op is a bubble

    word_t     adder_result;
    word_t     logic_result;
    word_t     shift_result;
    word_t     br_link;
    word_t     br_target;
    logic      br_jump;
    logic      br_we;

    word_t     bypass_q;                        // Bypass unit register
    xu_e       xu_q;                            // Selector for the mux
    tag_t      tag_q;
    logic      bubble_q;

    ////////////////////
    // Dispatcher
    assign bubble     = req_i.op == OP_NOTOKEN;
    assign req_fields = '{npc:  req_i.npc,
                          op_a: req_i.op_a,
                          op_b: req_i.op_b,
                          op_c: req_i.op_c,
                          op:   req_i.op};

    always_comb begin
        adder_req  = '0;                        // Idle units see OP_NOTOKEN
        logic_req  = '0;
        shift_req  = '0;
        branch_req = '0;
        case (req_i.xu)
            XU_ADDER:  adder_req  = req_fields;
            XU_LOGIC:  logic_req  = req_fields;
            XU_SHIFT:  shift_req  = req_fields;
            XU_BRANCH: branch_req = req_fields;
            default:   ;                        // Bypass handled below
        endcase
    end

    ////////////////////
    // Functional units
    adder_unit  u_adder  (.clk, .reset_i, .req_i(adder_req), .result_o(adder_result));
    logic_unit  u_logic  (.clk, .reset_i, .req_i(logic_req), .result_o(logic_result));
    shift_unit  u_shift  (.clk, .reset_i, .req_i(shift_req), .result_o(shift_result));
    branch_unit u_branch (
        .clk,
        .reset_i,
        .req_i    (branch_req),
        .link_o   (br_link),
        .target_o (br_target),
        .jump_o   (br_jump),
        .we_o     (br_we)
    );

    ////////////////////
    // Bypass and routing registers
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bypass_q <= '0;
            xu_q     <= XU_ADDER;
            tag_q    <= '0;
            bubble_q <= 1'b1;                   // No retire until first request
        end else begin
            bypass_q <= (req_i.xu == XU_BYPASS && !bubble) ? req_i.op_b : '0;
            xu_q     <= req_i.xu;
            tag_q    <= req_i.tag;
            bubble_q <= bubble;
        end
    end

    ////////////////////
    // Result multiplexer
    always_comb begin
        rsp_o         = '0;
        rsp_o.we      = 1'b1;                   // Plain ALU results write rd
        rsp_o.tag     = tag_q;
        case (xu_q)
            XU_ADDER: rsp_o.result0 = adder_result;
            XU_LOGIC: rsp_o.result0 = logic_result;
            XU_SHIFT: rsp_o.result0 = shift_result;
            XU_BRANCH: begin
                rsp_o.result0 = br_link;
                rsp_o.result1 = br_target;
                rsp_o.jump    = br_jump;
                rsp_o.we      = br_we;
            end
            default:  rsp_o.result0 = bypass_q; // Bypass
        endcase
        if (bubble_q) begin
            rsp_o.we   = 1'b0;                  // Results pass, side effects dropped
            rsp_o.jump = 1'b0;
        end
    end

endmodule

/* execute/branch_unit.sv */
module branch_unit (
    input  logic                   clk,
    input  logic                   reset_i,
    input  execute_pkg::unit_req_t req_i,       // Operands from dispatcher
    output execute_pkg::word_t     link_o,      // Return address for jumps
    output execute_pkg::word_t     target_o,    // Branch or jump target
    output logic                   jump_o,      // Taken
    output logic                   we_o         // Link write enable
);
    import execute_pkg::*;

    word_t pc_target;                           // npc + offset
    word_t reg_target;                          // JALR target, bit 0 cleared
    word_t pc_link;                             // npc + 4
    logic  eq;
    logic  lt_s;
    logic  lt_u;
    word_t link_d;
    word_t target_d;
    logic  jump_d;
    logic  we_d;

    assign pc_target  = req_i.npc + req_i.op_c;
    assign reg_target = (req_i.op_a + req_i.op_c) & ~word_t'(1);
    assign pc_link    = req_i.npc + word_t'(4);
    assign eq         = req_i.op_a == req_i.op_b;
    assign lt_s       = $signed(req_i.op_a) < $signed(req_i.op_b);
    assign lt_u       = req_i.op_a < req_i.op_b;

    always_comb begin
        link_d   = '0;                          // Bubble defaults
        target_d = '0;
        jump_d   = 1'b0;
        we_d     = 1'b0;
        case (req_i.op)
            OP_BEQ:  begin target_d = pc_target; jump_d = eq;    end
            OP_BNE:  begin target_d = pc_target; jump_d = !eq;   end
            OP_BLT:  begin target_d = pc_target; jump_d = lt_s;  end
            OP_BGE:  begin target_d = pc_target; jump_d = !lt_s; end
            OP_BLTU: begin target_d = pc_target; jump_d = lt_u;  end
            OP_BGEU: begin target_d = pc_target; jump_d = !lt_u; end
            OP_JAL, OP_JALR: begin
                target_d = (req_i.op == OP_JAL) ? pc_target : reg_target;
                link_d   = pc_link;             // Written back to rd
                jump_d   = 1'b1;
                we_d     = 1'b1;
            end
            default: ;                          // Bubble keeps zeros
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            link_o   <= '0;
            target_o <= '0;
            jump_o   <= 1'b0;
            we_o     <= 1'b0;
        end else begin
            link_o   <= link_d;
            target_o <= target_d;
            jump_o   <= jump_d;
            we_o     <= we_d;
        end
    end

endmodule

/* execute/shift_unit.sv */
module shift_unit (
    input  logic                   clk,
    input  logic                   reset_i,
    input  execute_pkg::unit_req_t req_i,       // Operands from dispatcher
    output execute_pkg::word_t     result_o     // Registered result
);
    import execute_pkg::*;

    logic [SHAMT_W-1:0] shamt;                  // Low bits of operand B
    word_t              result_d;               // Next result

    assign shamt = req_i.op_b[SHAMT_W-1:0];

    always_comb begin
        case (req_i.op)
            OP_SLL:  result_d = req_i.op_a << shamt;
            OP_SRL:  result_d = req_i.op_a >> shamt;    // Zero fill
            OP_SRA:  result_d = word_t'($signed(req_i.op_a) >>> shamt);  // Sign fill
            default: result_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_o <= '0;
        end else begin
            result_o <= result_d;
        end
    end

endmodule

/* execute/logic_unit.sv */
module logic_unit (
    input  logic                   clk,
    input  logic                   reset_i,
    input  execute_pkg::unit_req_t req_i,       // Operands from dispatcher
    output execute_pkg::word_t     result_o     // Registered result
);
    import execute_pkg::*;

    word_t result_d;                            // Next result

    always_comb begin
        case (req_i.op)
            OP_AND:  result_d = req_i.op_a & req_i.op_b;
            OP_OR:   result_d = req_i.op_a | req_i.op_b;
            OP_XOR:  result_d = req_i.op_a ^ req_i.op_b;
            default: result_d = '0;             // Bubble clears
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_o <= '0;
        end else begin
            result_o <= result_d;
        end
    end

endmodule

/* execute/adder_unit.sv */
module adder_unit (
    input  logic                   clk,
    input  logic                   reset_i,
    input  execute_pkg::unit_req_t req_i,       // Operands from dispatcher
    output execute_pkg::word_t     result_o     // Registered result
);
    import execute_pkg::*;

    word_t result_d;                            // Next result
    logic  lt_signed;                           // Signed A < B
    logic  lt_unsigned;                         // Unsigned A < B

    assign lt_signed   = $signed(req_i.op_a) < $signed(req_i.op_b);
    assign lt_unsigned = req_i.op_a < req_i.op_b;

    always_comb begin
        case (req_i.op)
            OP_ADD:  result_d = req_i.op_a + req_i.op_b;
            OP_SUB:  result_d = req_i.op_a - req_i.op_b;
            OP_SLT:  result_d = word_t'(lt_signed);     // Zero extended flag
            OP_SLTU: result_d = word_t'(lt_unsigned);
            default: result_d = '0;                     // Bubble or foreign op
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_o <= '0;
        end else begin
            result_o <= result_d;
        end
    end

endmodule

/* common/execute_pkg.sv */
package execute_pkg;

    ////////////////////
    // Widths fixed by the core
    localparam int XLEN    = 32;                // Data word width
    localparam int TAG_W   = 4;                 // Instruction tag width
    localparam int SHAMT_W = $clog2(XLEN);      // Shift amount bits

    typedef logic [XLEN-1:0]  word_t;           // Data word
    typedef logic [TAG_W-1:0] tag_t;            // Instruction tag

    ////////////////////
    // Functional unit selector
    typedef enum logic [2:0] {
        XU_ADDER  = 3'd0,                       // ADD SUB SLT SLTU
        XU_LOGIC  = 3'd1,                       // AND OR XOR
        XU_SHIFT  = 3'd2,                       // SLL SRL SRA
        XU_BRANCH = 3'd3,                       // Branches and jumps
        XU_BYPASS = 3'd4                        // Operand B passthrough
    } xu_e;

    ////////////////////
    // Operation codes, zero is the bubble
    typedef enum logic [4:0] {
        OP_NOTOKEN = 5'd0,                      // Bubble
        OP_ADD, OP_SUB, OP_SLT, OP_SLTU,        // Adder
        OP_AND, OP_OR, OP_XOR,                  // Logic
        OP_SLL, OP_SRL, OP_SRA,                 // Shift
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE,         // Signed and equality branches
        OP_BLTU, OP_BGEU,                       // Unsigned branches
        OP_JAL, OP_JALR                         // Jumps
    } op_e;

    // Request from operand fetch, 140 bits
    typedef struct packed {
        word_t npc;                             // Instruction address
        word_t op_a;                            // Operand A
        word_t op_b;                            // Operand B
        word_t op_c;                            // Branch offset
        op_e   op;                              // Operation
        xu_e   xu;                              // Target unit
        tag_t  tag;                             // Instruction tag
    } exe_req_t;

    // Operands seen by one unit, 133 bits
    typedef struct packed {
        word_t npc;
        word_t op_a;
        word_t op_b;
        word_t op_c;
        op_e   op;
    } unit_req_t;

    // Response toward retire, 70 bits
    typedef struct packed {
        word_t result0;                         // Main result or link
        word_t result1;                         // Branch target
        logic  jump;                            // Branch taken
        logic  we;                              // Register write enable
        tag_t  tag;
    } exe_rsp_t;

endpackage
